// File: rtl/user_io_pkg.sv
/* register map and shared types of the user input block
   addresses are word addresses (byte address / 2), data words are 16 bits
   joystick lines are active low, mouse buttons active high */
package user_io_pkg;

	// ----------------------------------------
	// types
	// ----------------------------------------
	typedef logic [15:0] word_t;    // one custom register data word
	typedef logic [7:0] reg_addr_t; // word address on the register bus
	typedef logic [7:0] pos_t;      // one mouse axis counter, wraps mod 256
	typedef logic [5:0] joy_t;      // {fire2, fire, right, left, down, up}
	typedef logic [3:0] quad_t;     // {x pair, y pair}

	// line positions inside joy_t
	localparam int JOY_UP    = 0;
	localparam int JOY_DOWN  = 1;
	localparam int JOY_LEFT  = 2;
	localparam int JOY_RIGHT = 3;
	localparam int JOY_FIRE  = 4;
	localparam int JOY_FIRE2 = 5;

	// mouse button positions
	localparam int MB_LEFT  = 0;
	localparam int MB_RIGHT = 1;

	// ----------------------------------------
	// register map
	// ----------------------------------------
	localparam reg_addr_t REG_JOY0DAT = 8'h05; // mouse counters, y:x
	localparam reg_addr_t REG_JOY1DAT = 8'h06; // port 2 directions
	localparam reg_addr_t REG_POTINP  = 8'h0B; // pot pin readback
	localparam reg_addr_t REG_POTGO   = 8'h1A; // pot pin control, write only
	localparam reg_addr_t REG_NOOP    = 8'hFF; // idle bus address

	// POTINP layout
	localparam int POT_P1_FIRE2 = 10; // port 1 second button / right mouse button
	localparam int POT_P2_FIRE2 = 14; // port 2 second button
	localparam word_t POT_DATA_BITS = 16'h5500; // bits 14, 12, 10, 8

endpackage

// File: rtl/mouse_quadrature.sv
/* mouse quadrature decoder, one count per quadrature edge
   inputs are asynchronous, synchronized here; counts appear two cycles after a line change */
module mouse_quadrature (
	input logic clk,
	input logic cpurst,
	input user_io_pkg::quad_t mouse_quad_i, // {xb, xa, yb, ya}, asynchronous
	output user_io_pkg::pos_t mouse_x_o,    // horizontal counter
	output user_io_pkg::pos_t mouse_y_o     // vertical counter
);

	user_io_pkg::quad_t quad_s1; // first sync stage, holds the new pair values
	user_io_pkg::quad_t quad_s2; // second stage, holds the previous values

	logic x_step; // x pair changed
	logic y_step; // y pair changed
	logic x_up;   // x direction
	logic y_up;   // y direction

	// ----------------------------------------
	// synchronizer
	// ----------------------------------------
	// stages keep tracking through reset, so leaving reset
	// finds s1 == s2 and no count is made
	always_ff @(posedge clk) begin
		quad_s1 <= mouse_quad_i;
		quad_s2 <= quad_s1;
	end

	// an axis moves when its pair differs between the stages
	assign x_step = quad_s1[3:2] != quad_s2[3:2];
	assign y_step = quad_s1[1:0] != quad_s2[1:0];

	// up when new low bit differs from old high bit
	assign x_up = quad_s1[2] ^ quad_s2[3];
	assign y_up = quad_s1[0] ^ quad_s2[1];

	// one step of an axis counter, modulo 256
	function automatic user_io_pkg::pos_t axis_next(
		input user_io_pkg::pos_t cnt,
		input logic step,
		input logic up
	);
		if (!step)
			return cnt; // pair unchanged
		else if (up)
			return cnt + 8'd1;
		else
			return cnt - 8'd1;
	endfunction

	// ----------------------------------------
	// position counters
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (cpurst) begin
			mouse_x_o <= '0;
			mouse_y_o <= '0;
		end else begin
			mouse_x_o <= axis_next(mouse_x_o, x_step, x_up);
			mouse_y_o <= axis_next(mouse_y_o, y_step, y_up);
		end
	end

endmodule

// File: rtl/joystick_port.sv
/* port 2 direction encoder, POTGO register, POTINP readback and fire lines
   combinational except POTGO, which loads on the edge that sees its write strobe */
module joystick_port (
	input logic clk,
	input logic cpurst,
	input user_io_pkg::joy_t n_joy1_i,   // port 1 lines, active low
	input user_io_pkg::joy_t n_joy2_i,   // port 2 lines, active low
	input logic [1:0] mouse_buttons_i,   // {right, left}, active high
	input logic potgo_wr_i,              // write strobe from the decoder
	input user_io_pkg::word_t potgo_data_i, // register bus write data
	output user_io_pkg::word_t joy1dat_o,   // JOY1DAT read value
	output user_io_pkg::word_t potinp_o,    // POTINP read value
	output logic [1:0] n_fire_o             // fire lines to the peripheral adapter
);

	// port 2 directions, high when pressed
	logic up_p;
	logic down_p;
	logic left_p;
	logic right_p;

	user_io_pkg::word_t potgo_q;  // last POTGO write
	user_io_pkg::word_t pot_gate; // pins pulled low by buttons

	assign up_p    = !n_joy2_i[user_io_pkg::JOY_UP];
	assign down_p  = !n_joy2_i[user_io_pkg::JOY_DOWN];
	assign left_p  = !n_joy2_i[user_io_pkg::JOY_LEFT];
	assign right_p = !n_joy2_i[user_io_pkg::JOY_RIGHT];

	// ----------------------------------------
	// JOY1DAT
	// ----------------------------------------
	// counter style encoding: bit 1 is the direction, bit 0 its xor with the
	// neighbour, so software decodes it like a mouse counter
	always_comb begin
		joy1dat_o = '0;
		joy1dat_o[9] = left_p;          // y1
		joy1dat_o[8] = left_p ^ up_p;   // y0
		joy1dat_o[1] = right_p;         // x1
		joy1dat_o[0] = right_p ^ down_p; // x0
	end

	// ----------------------------------------
	// POTGO / POTINP
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (cpurst)
			potgo_q <= '0;
		else if (potgo_wr_i)
			potgo_q <= potgo_data_i; // visible on POTINP next cycle
	end

	// a pressed second button shorts its pot pin to ground
	always_comb begin
		pot_gate = '1;
		pot_gate[user_io_pkg::POT_P2_FIRE2] = n_joy2_i[user_io_pkg::JOY_FIRE2];
		pot_gate[user_io_pkg::POT_P1_FIRE2] = n_joy1_i[user_io_pkg::JOY_FIRE2]
			& !mouse_buttons_i[user_io_pkg::MB_RIGHT]; // right button shares port 1 pin
	end

	assign potinp_o = potgo_q & pot_gate & user_io_pkg::POT_DATA_BITS; // only data pins read back

	// ----------------------------------------
	// fire lines
	// ----------------------------------------
	assign n_fire_o[1] = n_joy2_i[user_io_pkg::JOY_FIRE];
	assign n_fire_o[0] = n_joy1_i[user_io_pkg::JOY_FIRE]
		& !mouse_buttons_i[user_io_pkg::MB_LEFT]; // left button acts as port 1 fire

endmodule

// File: rtl/user_reg_decode.sv
/* custom register decoder of the user input block, purely combinational
   unmatched addresses read zero so the result can be ORed onto a shared read bus */
module user_reg_decode (
	input user_io_pkg::reg_addr_t reg_address_i, // register bus address, word units
	input user_io_pkg::pos_t mouse_x_i,          // mouse x counter
	input user_io_pkg::pos_t mouse_y_i,          // mouse y counter
	input user_io_pkg::word_t joy1dat_i,         // encoded port 2 directions
	input user_io_pkg::word_t potinp_i,          // pot pin readback
	output logic potgo_wr_o,                     // POTGO write strobe
	output user_io_pkg::word_t reg_data_o        // read data
);

	// ----------------------------------------
	// address decode and read mux
	// ----------------------------------------
	// the bus has no read/write qualifier and the address alone
	// selects, so POTGO loads for every cycle it is addressed
	always_comb begin
		potgo_wr_o = 1'b0;
		reg_data_o = '0;
		case (reg_address_i)
			user_io_pkg::REG_JOY0DAT: begin
				reg_data_o = {mouse_y_i, mouse_x_i}; // y in the high byte
			end
			user_io_pkg::REG_JOY1DAT: begin
				reg_data_o = joy1dat_i;
			end
			user_io_pkg::REG_POTINP: begin
				reg_data_o = potinp_i;
			end
			user_io_pkg::REG_POTGO: begin
				potgo_wr_o = 1'b1; // write only, reads back zero
			end
			default: begin
				reg_data_o = '0; // idle bus or register of another chip
			end
		endcase
	end

endmodule

// File: rtl/user_io.sv
/* user input register block: mouse counters, joystick port, pot pins
   read data valid in the same cycle as the address; no bus handshake */
module user_io (
	input logic clk,
	input logic cpurst,
	input user_io_pkg::reg_addr_t reg_address_i, // register address, word units
	input user_io_pkg::word_t reg_data_i,        // register write data
	input user_io_pkg::quad_t mouse_quad_i,      // asynchronous quadrature lines
	input logic [1:0] mouse_buttons_i,           // {right, left}, active high
	input user_io_pkg::joy_t n_joy1_i,           // port 1, active low
	input user_io_pkg::joy_t n_joy2_i,           // port 2, active low
	output user_io_pkg::word_t reg_data_o,       // read data, zero when not addressed
	output logic [1:0] n_fire_o                  // fire lines, bit 0 port 1
);

	user_io_pkg::pos_t mouse_x;   // x counter
	user_io_pkg::pos_t mouse_y;   // y counter
	user_io_pkg::word_t joy1dat;  // encoded port 2
	user_io_pkg::word_t potinp;   // pot readback
	logic potgo_wr;               // POTGO addressed this cycle

	// ----------------------------------------
	// input side
	// ----------------------------------------
	mouse_quadrature i_mouse_quadrature (
		.clk          (clk),
		.cpurst       (cpurst),
		.mouse_quad_i (mouse_quad_i),
		.mouse_x_o    (mouse_x),
		.mouse_y_o    (mouse_y)
	);

	joystick_port i_joystick_port (
		.clk             (clk),
		.cpurst          (cpurst),
		.n_joy1_i        (n_joy1_i),
		.n_joy2_i        (n_joy2_i),
		.mouse_buttons_i (mouse_buttons_i),
		.potgo_wr_i      (potgo_wr),
		.potgo_data_i    (reg_data_i),
		.joy1dat_o       (joy1dat),
		.potinp_o        (potinp),
		.n_fire_o        (n_fire_o)
	);

	// ----------------------------------------
	// register bus side
	// ----------------------------------------
	user_reg_decode i_user_reg_decode (
		.reg_address_i (reg_address_i),
		.mouse_x_i     (mouse_x),
		.mouse_y_i     (mouse_y),
		.joy1dat_i     (joy1dat),
		.potinp_i      (potinp),
		.potgo_wr_o    (potgo_wr),
		.reg_data_o    (reg_data_o)
	);

endmodule

// File: verification/user_io_properties.sv
/* concurrent checks on the user_io register bus, bound into every user_io instance
   sampled on the rising edge; failures are also counted for the testbench summary */
module user_io_properties (
	input logic clk,
	input logic cpurst,
	input user_io_pkg::reg_addr_t reg_address_i, // bus address seen by the decoder
	input user_io_pkg::word_t read_data_i,       // reg_data_o of user_io
	input logic potgo_wr_i,                      // decoder write strobe
	input user_io_pkg::pos_t mouse_x_i,          // x counter
	input user_io_pkg::pos_t mouse_y_i           // y counter
);

	int unsigned assert_fails = 0; // read by the testbench at the end of the run

	logic readable; // address of one of the three read registers

	assign readable = (reg_address_i == user_io_pkg::REG_JOY0DAT)
		|| (reg_address_i == user_io_pkg::REG_JOY1DAT)
		|| (reg_address_i == user_io_pkg::REG_POTINP);

	// ----------------------------------------
	// register bus
	// ----------------------------------------
	potgo_strobe_only_on_potgo: assert property (@(posedge clk)
		potgo_wr_i |-> reg_address_i == user_io_pkg::REG_POTGO)
		else begin
			assert_fails++;
			$error("POTGO write strobe high at address %h", reg_address_i);
		end

	// other chips OR their data onto the same bus
	zero_read_when_unmapped: assert property (@(posedge clk)
		!readable |-> read_data_i == '0)
		else begin
			assert_fails++;
			$error("read data %h on unmapped address %h", read_data_i, reg_address_i);
		end

	// ----------------------------------------
	// mouse counters
	// ----------------------------------------
	counters_clear_after_reset: assert property (@(posedge clk)
		cpurst |=> (mouse_x_i == '0) && (mouse_y_i == '0))
		else begin
			assert_fails++;
			$error("mouse counters not zero after reset: x %h y %h", mouse_x_i, mouse_y_i);
		end

endmodule

// File: verification/user_io_tb.sv
/* directed testbench of user_io; inputs change on rising edges, outputs sampled on falling
   quadrature steps are held 3 cycles since counts appear two cycles after a line change */
module user_io_tb;

	localparam int NUM_TESTS = 7;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 400;
	localparam user_io_pkg::word_t POT_PINS = 16'h5500; // pot data bits 14, 12, 10, 8

	logic clk = 1'b0;
	logic cpurst;
	user_io_pkg::reg_addr_t reg_address;
	user_io_pkg::word_t reg_wdata;
	user_io_pkg::word_t reg_rdata;
	user_io_pkg::quad_t mouse_quad;
	logic [1:0] mouse_buttons;   // {right, left}
	user_io_pkg::joy_t n_joy1;
	user_io_pkg::joy_t n_joy2;
	logic [1:0] n_fire;

	int seed = 29;           // random stream of the stepping and POTGO tests
	int errors = 0;          // failed compares over the whole run
	int test_start_errors;   // errors at the start of the running test
	int failed_tests = 0;
	user_io_pkg::pos_t model_x; // expected counters
	user_io_pkg::pos_t model_y;

	always #2 clk = ~clk; // period 4

	user_io i_user_io (
		.clk             (clk),
		.cpurst          (cpurst),
		.reg_address_i   (reg_address),
		.reg_data_i      (reg_wdata),
		.mouse_quad_i    (mouse_quad),
		.mouse_buttons_i (mouse_buttons),
		.n_joy1_i        (n_joy1),
		.n_joy2_i        (n_joy2),
		.reg_data_o      (reg_rdata),
		.n_fire_o        (n_fire)
	);

	bind user_io user_io_properties i_user_io_properties (
		.clk           (clk),
		.cpurst        (cpurst),
		.reg_address_i (reg_address_i),
		.read_data_i   (reg_data_o),
		.potgo_wr_i    (potgo_wr),
		.mouse_x_i     (mouse_x),
		.mouse_y_i     (mouse_y)
	);

	// ----------------------------------------
	// compare tasks and bookkeeping
	// ----------------------------------------
	task automatic check_word(input string name, input user_io_pkg::word_t expected,
		input user_io_pkg::word_t actual);
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_fire(input string name, input logic [1:0] expected,
		input logic [1:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic begin_test();
		test_start_errors = errors;
	endtask

	task automatic end_test(input string name);
		int n;
		n = errors - test_start_errors;
		if (n != 0)
			failed_tests++;
		$display("test %-14s done, %0d errors", name, n);
	endtask

	task automatic set_address(input user_io_pkg::reg_addr_t addr);
		@(posedge clk);
		reg_address <= addr;
	endtask

	// ----------------------------------------
	// mouse stimulus
	// ----------------------------------------
	// forward gray order 00 01 11 10, which the counter takes as up
	function automatic logic [1:0] gray_move(input logic [1:0] pair, input bit fwd);
		case (pair)
			2'b00: return fwd ? 2'b01 : 2'b10;
			2'b01: return fwd ? 2'b11 : 2'b00;
			2'b11: return fwd ? 2'b10 : 2'b01;
			default: return fwd ? 2'b00 : 2'b11;
		endcase
	endfunction

	// one quadrature edge on one axis, then JOY0DAT against the model
	task automatic mouse_step(input bit axis_x, input bit fwd);
		user_io_pkg::quad_t q;
		q = mouse_quad;
		if (axis_x) begin
			q[3:2] = gray_move(q[3:2], fwd);
			model_x = fwd ? model_x + 8'd1 : model_x - 8'd1;
		end else begin
			q[1:0] = gray_move(q[1:0], fwd);
			model_y = fwd ? model_y + 8'd1 : model_y - 8'd1;
		end
		@(posedge clk);
		mouse_quad <= q;
		repeat (3) @(posedge clk); // two sync stages, then the counter
		@(negedge clk);
		check_word("JOY0DAT", {model_y, model_x}, reg_rdata);
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------
	task automatic test_reset_values();
		begin_test();
		set_address(user_io_pkg::REG_JOY0DAT);
		@(negedge clk);
		check_word("JOY0DAT", 16'h0000, reg_rdata);
		set_address(user_io_pkg::REG_POTINP);
		@(negedge clk);
		check_word("POTINP", 16'h0000, reg_rdata);
		set_address(user_io_pkg::REG_NOOP);
		end_test("reset");
	endtask

	task automatic test_mouse_directed();
		begin_test();
		set_address(user_io_pkg::REG_JOY0DAT);
		for (int axis = 0; axis < 2; axis++) begin
			repeat (4) mouse_step(axis == 1, 1'b1);
			repeat (6) mouse_step(axis == 1, 1'b0); // ends below zero, wraps to 0xFE
		end
		set_address(user_io_pkg::REG_NOOP);
		end_test("mouse_directed");
	endtask

	task automatic test_mouse_random();
		logic [31:0] r;
		begin_test();
		set_address(user_io_pkg::REG_JOY0DAT);
		repeat (300) begin
			r = $random(seed);
			mouse_step(r[0], r[1] | r[2]); // biased forward, so the counters wrap
		end
		set_address(user_io_pkg::REG_NOOP);
		end_test("mouse_random");
	endtask

	task automatic test_joystick();
		logic [3:0] pressed; // {right, left, down, up}
		user_io_pkg::word_t expected;
		begin_test();
		set_address(user_io_pkg::REG_JOY1DAT);
		for (int d = 0; d < 16; d++) begin
			pressed = d[3:0];
			@(posedge clk);
			n_joy2 <= {2'b11, ~pressed};
			@(negedge clk);
			expected = '0;
			expected[9] = pressed[2];
			expected[8] = pressed[2] ^ pressed[0];
			expected[1] = pressed[3];
			expected[0] = pressed[3] ^ pressed[1];
			check_word("JOY1DAT", expected, reg_rdata);
		end
		@(posedge clk);
		n_joy2 <= 6'h3F;
		reg_address <= user_io_pkg::REG_NOOP;
		end_test("joystick");
	endtask

	// address POTGO for one cycle, then POTINP
	task automatic write_potgo(input user_io_pkg::word_t w);
		@(posedge clk);
		reg_address <= user_io_pkg::REG_POTGO;
		reg_wdata <= w;
		@(posedge clk);
		reg_address <= user_io_pkg::REG_POTINP;
	endtask

	task automatic test_potgo();
		user_io_pkg::word_t w;
		user_io_pkg::word_t expected;
		logic [2:0] c; // {right button, port 1 fire2, port 2 fire2}
		begin_test();
		repeat (8) begin
			w = $random(seed);
			write_potgo(w);
			@(negedge clk);
			check_word("POTINP", w & POT_PINS, reg_rdata);
			@(negedge clk);
			check_word("POTINP", w & POT_PINS, reg_rdata); // still held
		end
		write_potgo(16'hFFFF);
		for (int i = 0; i < 8; i++) begin
			c = i[2:0];
			@(posedge clk);
			n_joy2[5] <= ~c[0];
			n_joy1[5] <= ~c[1];
			mouse_buttons[1] <= c[2];
			@(negedge clk);
			expected = POT_PINS;
			if (c[0])
				expected[14] = 1'b0;
			if (c[1] | c[2])
				expected[10] = 1'b0;
			check_word("POTINP", expected, reg_rdata);
		end
		@(posedge clk);
		n_joy1 <= 6'h3F;
		n_joy2 <= 6'h3F;
		mouse_buttons <= 2'b00;
		reg_address <= user_io_pkg::REG_NOOP;
		end_test("potgo");
	endtask

	task automatic test_fire_lines();
		logic [3:0] c; // {right button, left button, port 2 fire, port 1 fire}
		begin_test();
		for (int i = 0; i < 16; i++) begin
			c = i[3:0];
			@(posedge clk);
			n_joy1 <= {1'b1, ~c[0], 4'hF};
			n_joy2 <= {1'b1, ~c[1], 4'hF};
			mouse_buttons <= c[3:2];
			@(negedge clk);
			check_fire("n_fire_o", {~c[1], ~c[0] & ~c[2]}, n_fire);
		end
		@(posedge clk);
		n_joy1 <= 6'h3F;
		n_joy2 <= 6'h3F;
		mouse_buttons <= 2'b00;
		end_test("fire");
	endtask

	task automatic test_unused_addresses();
		user_io_pkg::reg_addr_t a;
		begin_test();
		@(posedge clk);
		n_joy2 <= 6'h00;        // everything pressed, JOY1DAT nonzero
		reg_wdata <= 16'hFFFF;  // POTGO gets loaded while addressed
		for (int i = 0; i < 256; i++) begin
			a = i[7:0];
			if (a != user_io_pkg::REG_JOY0DAT && a != user_io_pkg::REG_JOY1DAT
				&& a != user_io_pkg::REG_POTINP) begin
				set_address(a);
				@(negedge clk);
				check_word($sformatf("reg_data_o @%h", a), 16'h0000, reg_rdata);
			end
		end
		@(posedge clk);
		n_joy2 <= 6'h3F;
		reg_address <= user_io_pkg::REG_NOOP;
		end_test("unused_addr");
	endtask

	// ----------------------------------------
	// run
	// ----------------------------------------
	initial begin
		int total;
		cpurst <= 1'b1;
		reg_address <= user_io_pkg::REG_NOOP;
		reg_wdata <= 16'h0000;
		mouse_quad <= 4'b0000;
		mouse_buttons <= 2'b00;
		n_joy1 <= 6'h3F; // all released
		n_joy2 <= 6'h3F;
		model_x = '0;
		model_y = '0;
		repeat (4) @(posedge clk);
		cpurst <= 1'b0;
		test_reset_values();
		test_mouse_directed();
		test_mouse_random();
		test_joystick();
		test_potgo();
		test_fire_lines();
		test_unused_addresses();
		repeat (2) @(posedge clk); // let the last assertions sample
		total = errors + i_user_io.i_user_io_properties.assert_fails;
		$display("tests %0d, failed tests %0d, check errors %0d, assertion failures %0d",
			NUM_TESTS, failed_tests, errors, i_user_io.i_user_io_properties.assert_fails);
		if (total == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("run timed out after %0d cycles without finishing the tests", TIMEOUT_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: user_io.f
rtl/user_io_pkg.sv
rtl/mouse_quadrature.sv
rtl/joystick_port.sv
rtl/user_reg_decode.sv
rtl/user_io.sv
verification/user_io_properties.sv
verification/user_io_tb.sv

// File: Bender.yml
package:
  name: user_io

sources:
  # synthesizable design, package first
  - rtl/user_io_pkg.sv
  - rtl/mouse_quadrature.sv
  - rtl/joystick_port.sv
  - rtl/user_reg_decode.sv
  - rtl/user_io.sv

  # testbench and bound assertions
  - target: any(simulation, test)
    files:
      - verification/user_io_properties.sv
      - verification/user_io_tb.sv
